// File: project.f
+incdir+source
source/axis_pkg.sv
source/axis_if.sv
source/axis_upsizer.sv
source/axis_downsizer.sv
source/axis_width_converter.sv
bench/resize_checks.sv
bench/resize_tb.sv

// File: Bender.yml
package:
  name: axis_width_converter

export_include_dirs:
  - source

sources:
  - source/axis_pkg.sv
  - source/axis_if.sv
  - source/axis_upsizer.sv
  - source/axis_downsizer.sv
  - source/axis_width_converter.sv
  - target: test
    files:
      - bench/resize_checks.sv
      - bench/resize_tb.sv

// File: bench/resize_tb.sv
// width converter testbench
// drives the 24-bit stream, shapes sink back-pressure and reports each test

`timescale 1ns/1ps
`default_nettype none

module resize_tb
  import axis_pkg::*;
();

  localparam int STREAM_WORDS = 40;
  localparam int BP_WORDS = 60;
  localparam int PKT_COUNT = 12;
  localparam int PKT_MAX = 20;
  localparam int STALL_WORDS = 12;
  localparam int STALL_WAIT = 24;
  localparam int TOTAL_WORDS = STREAM_WORDS + BP_WORDS + PKT_COUNT * PKT_MAX + STALL_WORDS;
  localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 4 + 400;

  // sink_ready patterns
  localparam int READY_HIGH = 0;
  localparam int READY_RANDOM = 1;
  localparam int READY_LOW = 2;

  logic            clk;
  logic            reset;
  in_word_t        src_data;
  logic            src_valid;
  logic            src_last;
  logic            src_ready;
  out_word_t       sink_data;
  logic            sink_valid;
  logic            sink_last;
  logic            sink_ready;

  int              ready_mode;
  logic [15:0]     data_lfsr;
  logic [15:0]     ready_lfsr;
  logic [8*16-1:0] test_name;
  logic            latency_on;
  int              words_sent;
  int              tb_errors;
  int              chk_errors;
  int              pending;
  int              tests_run;
  int              errors_before;

  axis_width_converter dut0 (
    .clk(clk),
    .reset(reset),
    .src_data(src_data),
    .src_valid(src_valid),
    .src_last(src_last),
    .src_ready(src_ready),
    .sink_data(sink_data),
    .sink_valid(sink_valid),
    .sink_last(sink_last),
    .sink_ready(sink_ready)
  );

  resize_checks chk0 (
    .clk(clk),
    .reset(reset),
    .test_name(test_name),
    .latency_on(latency_on),
    .src_data(src_data),
    .src_valid(src_valid),
    .src_last(src_last),
    .src_ready(src_ready),
    .sink_data(sink_data),
    .sink_valid(sink_valid),
    .sink_last(sink_last),
    .sink_ready(sink_ready),
    .errors(chk_errors),
    .pending(pending)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // galois lfsr, one step per bit taken, first bit ends up highest
  function automatic logic [31:0] take_bits(inout logic [15:0] state, input int n);
    logic [31:0] value;
    logic        bit_out;
    int          i;
    value = '0;
    for (i = 0; i < n; i++) begin
      bit_out = state[0];
      state = state >> 1;
      if (bit_out) begin
        state = state ^ 16'hB400;
      end
      value = {value[30:0], bit_out};
    end
    return value;
  endfunction

  function automatic int total_errors();
    return tb_errors + chk_errors;
  endfunction

  // sink back-pressure, about three beats in four accepted in random mode
  always @(posedge clk) begin
    #1;
    case (ready_mode)
      READY_RANDOM: sink_ready = (take_bits(ready_lfsr, 2) != 0);
      READY_LOW:    sink_ready = 1'b0;
      default:      sink_ready = 1'b1;
    endcase
  end

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("Error %0s %0s expected %0h actual %0h", test_name, what, expected, actual);
    tb_errors++;
  endtask

  task automatic start_test(input logic [8*16-1:0] name);
    test_name = name;
    errors_before = total_errors();
  endtask

  task automatic end_test();
    tests_run++;
    $display("test %0s finished, %0d errors", test_name, total_errors() - errors_before);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // holds the beat until a rising edge sees ready, then returns just after it
  task automatic send_word(input in_word_t data, input logic last);
    logic taken;
    src_data = data;
    src_valid = 1'b1;
    src_last = last;
    do begin
      @(negedge clk);
      taken = src_ready;
      @(posedge clk);
    end while (!taken);
    #1;
    words_sent++;
  endtask

  task automatic go_idle();
    src_valid = 1'b0;
    src_last = 1'b0;
    src_data = '0;
  endtask

  task automatic send_run(input int n);
    int i;
    for (i = 0; i < n; i++) begin
      send_word(in_word_t'(take_bits(data_lfsr, 24)), i == n - 1);
    end
    go_idle();
  endtask

  task automatic wait_drain();
    @(negedge clk);
    while (pending != 0) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic test_reset_state();
    start_test("reset");
    repeat (4) begin
      @(negedge clk);
      assert (src_ready === 1'b1) else report_mismatch("src_ready", 1, src_ready);
      assert (sink_valid === 1'b0) else report_mismatch("sink_valid", 0, sink_valid);
      assert (sink_last === 1'b0) else report_mismatch("sink_last", 0, sink_last);
    end
    @(posedge clk);
    #1;
    end_test();
  endtask

  task automatic test_packets();
    int p;
    int len;
    start_test("packets");
    ready_mode = READY_RANDOM;
    for (p = 0; p < PKT_COUNT; p++) begin
      len = 1 + int'(take_bits(data_lfsr, 5)) % PKT_MAX;
      send_run(len);
      idle_cycles(int'(take_bits(data_lfsr, 2)));
    end
    wait_drain();
    end_test();
  endtask

  // from an empty converter the two registers hold exactly two groups
  task automatic test_stall();
    int sent_before;
    start_test("stall");
    ready_mode = READY_LOW;
    idle_cycles(2);
    sent_before = words_sent;
    fork
      send_run(STALL_WORDS);
      begin
        repeat (STALL_WAIT) @(posedge clk);
        @(negedge clk);
        assert (words_sent - sent_before == 8)
          else report_mismatch("accepted words", 8, words_sent - sent_before);
        assert (src_ready === 1'b0) else report_mismatch("src_ready", 0, src_ready);
        @(posedge clk);
        #1;
        ready_mode = READY_HIGH;
      end
    join
    wait_drain();
    end_test();
  endtask

  initial begin
    reset = 1'b1;
    src_data = '0;
    src_valid = 1'b0;
    src_last = 1'b0;
    sink_ready = 1'b0;
    ready_mode = READY_HIGH;
    data_lfsr = 16'd3;
    ready_lfsr = 16'd3;
    test_name = "reset";
    latency_on = 1'b0;
    words_sent = 0;
    tb_errors = 0;
    tests_run = 0;
    errors_before = 0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    test_reset_state();

    start_test("stream");
    latency_on = 1'b1;
    send_run(STREAM_WORDS);
    wait_drain();
    latency_on = 1'b0;
    end_test();

    start_test("backpressure");
    ready_mode = READY_RANDOM;
    send_run(BP_WORDS);
    wait_drain();
    end_test();

    test_packets();
    test_stall();

    $display("tests run %0d, failed checks %0d", tests_run, total_errors());
    if (total_errors() == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the stream stopped moving", WATCHDOG_CYCLES);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/resize_checks.sv
// width converter checker
// reference byte queue with zero padding per packet, compared by assertions

`timescale 1ns/1ps
`default_nettype none

`include "axis_macros.svh"

module resize_checks
  import axis_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic [8*16-1:0] test_name,
  input  logic            latency_on,
  input  in_word_t        src_data,
  input  logic            src_valid,
  input  logic            src_last,
  input  logic            src_ready,
  input  out_word_t       sink_data,
  input  logic            sink_valid,
  input  logic            sink_last,
  input  logic            sink_ready,
  output int              errors,
  output int              pending
);

  localparam int WIDE_BYTES = `AXIS_DWIDTH_WIDE / 8;
  localparam int IN_BYTES = `AXIS_DWIDTH_IN / 8;
  localparam int OUT_BYTES = `AXIS_DWIDTH_OUT / 8;

  logic [7:0] byte_q[$];
  logic       end_q[$];
  int         beats_q[$];

  int         fill;
  int         in_slot;
  int         words_in_pkt;
  int         out_beats;

  // expectations for the transfer at the next rising edge
  out_word_t  exp_word;
  logic       exp_last;
  logic       have_word;
  int         exp_beats;
  int         beats_seen;
  logic       group_end;

  initial begin
    errors = 0;
    have_word = 1'b0;
    group_end = 1'b0;
  end

  task automatic push_byte(input logic [7:0] value);
    byte_q.push_back(value);
    end_q.push_back(1'b0);
    fill = (fill + 1) % WIDE_BYTES;
  endtask

  // inputs settle after the bench drive, so mid-cycle shows the coming transfer
  always @(negedge clk) begin
    if (reset) begin
      byte_q.delete();
      end_q.delete();
      beats_q.delete();
      fill = 0;
      in_slot = 0;
      words_in_pkt = 0;
      out_beats = 0;
      have_word = 1'b0;
      group_end = 1'b0;
    end else begin
      have_word = (byte_q.size() >= OUT_BYTES);
      if (have_word) begin
        for (int k = 0; k < OUT_BYTES; k++) begin
          exp_word[8*k +: 8] = byte_q[k];
        end
        exp_last = end_q[OUT_BYTES-1];
      end
      exp_beats = (beats_q.size() > 0) ? beats_q[0] : 0;
      beats_seen = out_beats;
      group_end = src_valid && src_ready && (src_last || in_slot == `AXIS_UP - 1);

      if (sink_valid && sink_ready && have_word) begin
        repeat (OUT_BYTES) begin
          void'(byte_q.pop_front());
          void'(end_q.pop_front());
        end
        if (sink_last) begin
          out_beats = 0;
          if (beats_q.size() > 0) begin
            void'(beats_q.pop_front());
          end
        end else begin
          out_beats++;
        end
      end

      if (src_valid && src_ready) begin
        for (int k = 0; k < IN_BYTES; k++) begin
          push_byte(src_data[8*k +: 8]);
        end
        words_in_pkt++;
        in_slot = (src_last || in_slot == `AXIS_UP - 1) ? 0 : in_slot + 1;
        // packet end pads to the next wide word and marks its final byte
        if (src_last) begin
          while (fill != 0) begin
            push_byte(8'h00);
          end
          end_q[end_q.size()-1] = 1'b1;
          beats_q.push_back(`AXIS_DOWN * ((words_in_pkt + `AXIS_UP - 1) / `AXIS_UP));
          words_in_pkt = 0;
        end
      end
      pending = byte_q.size();
    end
  end

  no_extra_word: assert property (
    @(posedge clk) disable iff (reset)
    sink_valid |-> have_word
  ) else begin
    errors++;
    $display("%0s: output word appeared with no input bytes left to match", test_name);
  end

  data_order: assert property (
    @(posedge clk) disable iff (reset)
    sink_valid && sink_ready && have_word |-> sink_data == exp_word
  ) else begin
    errors++;
    $display("Error %0s sink_data expected %h actual %h",
      test_name, $sampled(exp_word), $sampled(sink_data));
  end

  last_position: assert property (
    @(posedge clk) disable iff (reset)
    sink_valid && sink_ready && have_word |-> sink_last == exp_last
  ) else begin
    errors++;
    $display("Error %0s sink_last expected %b actual %b",
      test_name, $sampled(exp_last), $sampled(sink_last));
  end

  beats_per_packet: assert property (
    @(posedge clk) disable iff (reset)
    sink_valid && sink_ready && sink_last |-> beats_seen + 1 == exp_beats
  ) else begin
    errors++;
    $display("Error %0s beats per packet expected %0d actual %0d",
      test_name, $sampled(exp_beats), $sampled(beats_seen) + 1);
  end

  stall_stable: assert property (
    @(posedge clk) disable iff (reset)
    sink_valid && !sink_ready |=> sink_valid && $stable(sink_data) && $stable(sink_last)
  ) else begin
    errors++;
    $display("%0s: output beat changed or dropped while sink_ready was low", test_name);
  end

  // with the sink always ready a closed group shows up two cycles later
  group_latency: assert property (
    @(posedge clk) disable iff (reset)
    latency_on && group_end |-> ##2 sink_valid
  ) else begin
    errors++;
    $display("%0s: no output word two cycles after an input group closed", test_name);
  end

endmodule

`default_nettype wire

// File: source/axis_width_converter.sv
// axi-stream width converter, 24 to 32 bits
// upsizer packs four input beats into 96 bits, downsizer emits three output beats
// packets that end mid-group are zero padded to the next 96-bit boundary

`timescale 1ns/1ps
`default_nettype none

`include "axis_macros.svh"

module axis_width_converter
  import axis_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  // input stream
  input  in_word_t  src_data,
  input  logic      src_valid,
  input  logic      src_last,
  output logic      src_ready,

  // output stream
  output out_word_t sink_data,
  output logic      sink_valid,
  output logic      sink_last,
  input  logic      sink_ready
);

  // both stages must meet at the same wide width
  if (`AXIS_DWIDTH_WIDE != `AXIS_DWIDTH_OUT * `AXIS_DOWN) begin : g_width_check
    $error("wide word does not split evenly into output words");
  end

  axis_if #(.DWIDTH(`AXIS_DWIDTH_IN))   narrow_if ();
  axis_if #(.DWIDTH(`AXIS_DWIDTH_WIDE)) wide_if ();
  axis_if #(.DWIDTH(`AXIS_DWIDTH_OUT))  out_if ();

  // input ports onto the narrow link
  assign narrow_if.data = src_data;
  assign narrow_if.valid = src_valid;
  assign narrow_if.last = src_last;
  assign src_ready = narrow_if.ready;

  // output link onto the sink ports
  assign sink_data = out_if.data;
  assign sink_valid = out_if.valid;
  assign sink_last = out_if.last;
  assign out_if.ready = sink_ready;

  axis_upsizer #(
    .DWIDTH(`AXIS_DWIDTH_IN),
    .UP(`AXIS_UP)
  ) up0 (
    .clk,
    .reset,
    .narrow(narrow_if.sink),
    .wide(wide_if.source)
  );

  axis_downsizer #(
    .DWIDTH(`AXIS_DWIDTH_WIDE),
    .DOWN(`AXIS_DOWN)
  ) down0 (
    .clk,
    .reset,
    .wide(wide_if.sink),
    .narrow(out_if.source)
  );

endmodule

`default_nettype wire

// File: source/axis_downsizer.sv
// axi-stream downsizer
// splits one wide beat into DOWN narrow beats with the lowest subword first
// last goes out only with the final subword

`timescale 1ns/1ps
`default_nettype none

`include "axis_macros.svh"

module axis_downsizer #(
  parameter int DWIDTH = `AXIS_DWIDTH_WIDE,
  parameter int DOWN = `AXIS_DOWN
) (
  input logic    clk,
  input logic    reset,
  axis_if.sink   wide,
  axis_if.source narrow
);

  localparam int OUT_W = DWIDTH / DOWN;
  localparam int IDX_W = (DOWN > 1) ? $clog2(DOWN) : 1;
  localparam logic [IDX_W-1:0] IDX_MAX = IDX_W'(DOWN - 1);

  logic [DWIDTH-1:0] hold;
  logic [IDX_W-1:0]  idx;
  logic              full;
  logic              hold_last;

  logic final_sub;
  logic take_in;
  logic take_out;

  assign final_sub = (idx == IDX_MAX);
  assign take_in = wide.valid && wide.ready;
  assign take_out = full && narrow.ready;

  // room when empty or when the final subword leaves this cycle
  assign wide.ready = !full || (narrow.ready && final_sub);

  assign narrow.valid = full;
  assign narrow.data = hold[idx*OUT_W +: OUT_W];
  assign narrow.last = full && hold_last && final_sub;

  // subword index and full flag
  always_ff @(posedge clk) begin
    if (reset) begin
      idx <= '0;
      full <= 1'b0;
      hold_last <= 1'b0;
    end else begin
      if (take_out) begin
        if (final_sub) begin
          idx <= '0;
        end else begin
          idx <= idx + 1'b1;
        end
      end

      // reload wins over release when both happen together
      if (take_in) begin
        full <= 1'b1;
        hold_last <= wide.last;
      end else if (take_out && final_sub) begin
        full <= 1'b0;
      end
    end
  end

  // holding register
  always_ff @(posedge clk) begin
    if (take_in) begin
      hold <= wide.data;
    end
  end

  // a beat with last ends its wide word and the next beat starts at subword 0
  last_on_final: assert property (
    @(posedge clk) disable iff (reset)
    narrow.valid && narrow.ready && narrow.last |=> idx == '0
  ) else $error("downsizer last left before the final subword");

  // stalled output beat stays put until it is taken
  narrow_hold: assert property (
    @(posedge clk) disable iff (reset)
    narrow.valid && !narrow.ready |=>
      narrow.valid && $stable(narrow.data) && $stable(narrow.last)
  ) else $error("downsizer output beat changed under back-pressure");

endmodule

`default_nettype wire

// File: source/axis_upsizer.sv
// axi-stream upsizer
// gathers UP narrow beats into one wide beat, lowest slot first
// a beat with last closes the group early, unused slots stay zero

`timescale 1ns/1ps
`default_nettype none

`include "axis_macros.svh"

module axis_upsizer #(
  parameter int DWIDTH = `AXIS_DWIDTH_IN,
  parameter int UP = `AXIS_UP
) (
  input logic    clk,
  input logic    reset,
  axis_if.sink   narrow,
  axis_if.source wide
);

  localparam int WIDE_W = DWIDTH * UP;
  localparam int SLOT_W = (UP > 1) ? $clog2(UP) : 1;
  localparam logic [SLOT_W-1:0] SLOT_MAX = SLOT_W'(UP - 1);

  logic [SLOT_W-1:0] slot;
  logic [WIDE_W-1:0] acc;
  logic              full;
  logic              acc_last;

  logic take_in;
  logic take_out;
  logic group_done;

  assign take_in = narrow.valid && narrow.ready;
  assign take_out = full && wide.ready;

  // group closes on the last slot or on packet end
  assign group_done = take_in && (narrow.last || (slot == SLOT_MAX));

  // accept while not full, or while the full word leaves this cycle
  assign narrow.ready = !full || wide.ready;

  assign wide.valid = full;
  assign wide.data = acc;
  assign wide.last = acc_last;

  // slot counter and full flag
  always_ff @(posedge clk) begin
    if (reset) begin
      slot <= '0;
      full <= 1'b0;
      acc_last <= 1'b0;
    end else begin
      if (take_in) begin
        if (group_done) begin
          slot <= '0;
        end else begin
          slot <= slot + 1'b1;
        end
      end

      // a new group may close in the same cycle the old one leaves
      if (group_done) begin
        full <= 1'b1;
        acc_last <= narrow.last;
      end else if (take_out) begin
        full <= 1'b0;
      end
    end
  end

  // accumulator
  // slot 0 clears the upper slots, so a short group is zero padded
  always_ff @(posedge clk) begin
    if (take_in) begin
      if (slot == '0) begin
        acc <= WIDE_W'(narrow.data);
      end else begin
        acc[slot*DWIDTH +: DWIDTH] <= narrow.data;
      end
    end
  end

  // counter wraps before it passes the top slot
  slot_in_range: assert property (
    @(posedge clk) disable iff (reset)
    slot <= SLOT_MAX
  ) else $error("upsizer slot %0d beyond %0d", slot, SLOT_MAX);

  // a stalled wide beat keeps its payload until it is taken
  wide_hold: assert property (
    @(posedge clk) disable iff (reset)
    wide.valid && !wide.ready |=>
      wide.valid && $stable(wide.data) && $stable(wide.last)
  ) else $error("upsizer wide beat changed under back-pressure");

endmodule

`default_nettype wire

// File: source/axis_if.sv
// axi-stream link
// data, valid, ready and last between two stages of the converter

`timescale 1ns/1ps
`default_nettype none

interface axis_if #(
  parameter int DWIDTH = 32
);

  logic [DWIDTH-1:0] data;
  logic              valid;
  logic              ready;
  logic              last;

  // the side that produces beats
  modport source (
    output data,
    output valid,
    output last,
    input  ready
  );

  // the side that consumes beats
  modport sink (
    input  data,
    input  valid,
    input  last,
    output ready
  );

endinterface

`default_nettype wire

// File: source/axis_pkg.sv
// axis width converter types
// word types for the input, wide and output streams

`default_nettype none

`include "axis_macros.svh"

package axis_pkg;

  // one beat on the 24-bit input stream
  typedef logic [`AXIS_DWIDTH_IN-1:0] in_word_t;

  // one packed group of input beats, slot 0 in the low bits
  typedef logic [`AXIS_DWIDTH_WIDE-1:0] wide_word_t;

  // one beat on the 32-bit output stream
  typedef logic [`AXIS_DWIDTH_OUT-1:0] out_word_t;

endpackage

`default_nettype wire

// File: source/axis_macros.svh
// axis width converter parameters
// stream widths and packing ratios shared by the design and the bench

`ifndef AXIS_MACROS_SVH
`define AXIS_MACROS_SVH

// input stream word, three bytes
`define AXIS_DWIDTH_IN 24

// output stream word, four bytes
`define AXIS_DWIDTH_OUT 32

// narrow words gathered into one wide word
`define AXIS_UP 4

// output words split from one wide word
`define AXIS_DOWN 3

// common wide word between the two stages
// 24 x 4 = 96 = 32 x 3, the least common multiple of both widths
`define AXIS_DWIDTH_WIDE (`AXIS_DWIDTH_IN * `AXIS_UP)

`endif
